/* build.f */
verilog/tcb_pkg.sv
verilog/tcb_lib_decoder.sv
verilog/tcb_lib_demultiplexer.sv
verilog/tcb_sub_memory.sv
verilog/tcb_sub_gpio.sv
verilog/tcb_subsystem_top.sv
test/tcb_subsystem_assert.sv
test/tcb_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and decide the result from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tcb_subsystem_tb -o tcb_sim
./obj_dir/tcb_sim | tee sim.log
if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: test run ok"
else
  echo "run.sh: test run failed"
  exit 1
fi

/* test/tcb_subsystem_assert.sv */
// bus protocol properties, bound into every demultiplexer instance
`timescale 1ns/1ps

module tcb_subsystem_assert #(
  parameter int unsigned SPN = tcb_pkg::TCB_SPN_DEF
)(
  input logic           clk,
  input logic           rst_n,
  input logic           tcb_vld,
  input logic           tcb_err,
  input logic [SPN-1:0] sub_vld
);

  // at most one subordinate strobed
  a_sub_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sub_vld))
    else $error("sub_vld has more than one bit set");

  // error only answers a transfer of the previous cycle
  a_err_after_vld: assert property (@(posedge clk) disable iff (!rst_n)
    tcb_err |-> $past(tcb_vld))
    else $error("tcb_err high without a transfer in the previous cycle");

  // no subordinate strobe without a request
  a_sub_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
    !tcb_vld |-> (sub_vld == '0))
    else $error("sub_vld high while tcb_vld is low");

endmodule

bind tcb_lib_demultiplexer tcb_subsystem_assert #(
  .SPN (SPN)
) i_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .tcb_vld (tcb_vld),
  .tcb_err (tcb_err),
  .sub_vld (sub_vld)
);

/* test/tcb_subsystem_tb.sv */
// self-checking testbench that drives the bus subsystem top level with directed and random traffic
`timescale 1ns/1ps

module tcb_subsystem_tb;

  // gpio register offsets within the low address byte
  localparam logic [7:0]  GPIO_OUT_OFS = 8'h00;
  localparam logic [7:0]  GPIO_OE_OFS  = 8'h04;
  localparam logic [7:0]  GPIO_IN_OFS  = 8'h08;
  localparam int unsigned GPIO_W       = tcb_pkg::TCB_GPIO_W;
  localparam int unsigned MEM_WORDS    = 1024;
  // read attempts before the input poll gives up
  localparam int unsigned POLL_MAX     = 16;
  localparam int unsigned RAND_XFERS   = 500;

  logic              clk;
  logic              rst_n;
  logic              tcb_vld;
  logic              tcb_wen;
  tcb_pkg::tcb_adr_t tcb_adr;
  tcb_pkg::tcb_ben_t tcb_ben;
  tcb_pkg::tcb_dat_t tcb_wdt;
  tcb_pkg::tcb_dat_t tcb_rdt;
  logic              tcb_err;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;

  int unsigned err_cnt = 0;

  tcb_subsystem_top #(
    .SPN    (tcb_pkg::TCB_SPN_DEF),
    .DAM    (tcb_pkg::TCB_DAM_DEF),
    .DEPTH  (MEM_WORDS),
    .GPIO_W (GPIO_W)
  ) i_tcb_subsystem_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .tcb_vld  (tcb_vld),
    .tcb_wen  (tcb_wen),
    .tcb_adr  (tcb_adr),
    .tcb_ben  (tcb_ben),
    .tcb_wdt  (tcb_wdt),
    .tcb_rdt  (tcb_rdt),
    .tcb_err  (tcb_err),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  tcb_pkg::tcb_dat_t mem_m [0:MEM_WORDS-1];
  logic [GPIO_W-1:0] out_m;
  logic [GPIO_W-1:0] oe_m;
  // gpio_in delayed by one and two edges
  logic [GPIO_W-1:0] in_q1;
  logic [GPIO_W-1:0] in_q2;

  // expected error flag and read data derived from the address map
  function automatic logic [32:0] ref_response(input logic wen, input tcb_pkg::tcb_adr_t adr);
    tcb_pkg::tcb_dat_t rdt;
    logic              err;
    rdt = '0;
    err = 1'b0;
    if (adr[15:8] == 8'h10) begin
      // gpio block with zero for unused offsets
      if (!wen) begin
        case (adr[7:0] & 8'hfc)
          GPIO_OUT_OFS: rdt[GPIO_W-1:0] = out_m;
          GPIO_OE_OFS:  rdt[GPIO_W-1:0] = oe_m;
          GPIO_IN_OFS:  rdt[GPIO_W-1:0] = in_q2;
          default:      rdt = '0;
        endcase
      end
    end else if (adr[15:12] == 4'h0) begin
      if (!wen) rdt = mem_m[adr[11:2]];
    end else begin
      // unmapped
      err = 1'b1;
    end
    return {err, rdt};
  endfunction

  // apply a write to the model copies
  task automatic model_write(input tcb_pkg::tcb_adr_t adr, input tcb_pkg::tcb_ben_t ben,
                             input tcb_pkg::tcb_dat_t wdt);
    if (adr[15:8] == 8'h10) begin
      for (int i = 0; i < GPIO_W; i++) begin
        if (ben[i/8] && ((adr[7:0] & 8'hfc) == GPIO_OUT_OFS)) out_m[i] = wdt[i];
        if (ben[i/8] && ((adr[7:0] & 8'hfc) == GPIO_OE_OFS))  oe_m[i]  = wdt[i];
      end
    end else if (adr[15:12] == 4'h0) begin
      for (int b = 0; b < 4; b++) begin
        if (ben[b]) mem_m[adr[11:2]][8*b +: 8] = wdt[8*b +: 8];
      end
    end
  endtask

  // memory fill pattern over the whole address
  function automatic tcb_pkg::tcb_dat_t fill_word(input tcb_pkg::tcb_adr_t adr);
    return {adr ^ 16'h5ac3, ~adr};
  endfunction

  task automatic stop_with_error(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////////////////////////

  // expected values taken at the request edge and compared mid cycle
  initial begin : compare_responses
    logic [32:0]       exp_rsp;
    logic              chk;
    tcb_pkg::tcb_adr_t adr_q;
    exp_rsp = '0;
    chk     = 1'b0;
    adr_q   = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        out_m = '0;
        oe_m  = '0;
        chk   = 1'b0;
      end else begin
        // idle cycles answer zero
        exp_rsp = '0;
        if (tcb_vld) begin
          exp_rsp = ref_response(tcb_wen, tcb_adr);
          if (tcb_wen) model_write(tcb_adr, tcb_ben, tcb_wdt);
        end
        adr_q = tcb_adr;
        chk   = 1'b1;
      end
      in_q2 = in_q1;
      in_q1 = gpio_in;
      @(negedge clk);
      if (chk) begin
        assert (tcb_err === exp_rsp[32]) else
          stop_with_error($sformatf("Mismatch tcb_err: got %h expected %h (adr %h)",
                                    tcb_err, exp_rsp[32], adr_q));
        assert (tcb_rdt === exp_rsp[31:0]) else
          stop_with_error($sformatf("Mismatch tcb_rdt: got %h expected %h (adr %h)",
                                    tcb_rdt, exp_rsp[31:0], adr_q));
        // pins follow the model registers
        assert (gpio_out === out_m) else
          stop_with_error($sformatf("Mismatch gpio_out: got %h expected %h",
                                    gpio_out, out_m));
        assert (gpio_oe === oe_m) else
          stop_with_error($sformatf("Mismatch gpio_oe: got %h expected %h",
                                    gpio_oe, oe_m));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus driver
  //////////////////////////////////////////////////////////////////////

  // one transfer that returns 1 ns after its edge
  task automatic drive_xfer(input logic wen, input tcb_pkg::tcb_adr_t adr,
                            input tcb_pkg::tcb_ben_t ben, input tcb_pkg::tcb_dat_t wdt);
    tcb_vld = 1'b1;
    tcb_wen = wen;
    tcb_adr = adr;
    tcb_ben = ben;
    tcb_wdt = wdt;
    @(posedge clk);
    #1;
  endtask

  task automatic go_idle();
    tcb_vld = 1'b0;
    tcb_wen = 1'b0;
    tcb_adr = '0;
    tcb_ben = '0;
    tcb_wdt = '0;
  endtask

  task automatic read_word(input tcb_pkg::tcb_adr_t adr, output tcb_pkg::tcb_dat_t rdt);
    drive_xfer(1'b0, adr, 4'hf, '0);
    rdt = tcb_rdt;
    go_idle();
  endtask

  task automatic write_word(input tcb_pkg::tcb_adr_t adr, input tcb_pkg::tcb_ben_t ben,
                            input tcb_pkg::tcb_dat_t wdt);
    drive_xfer(1'b1, adr, ben, wdt);
    go_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    tcb_pkg::tcb_dat_t rd;
    tcb_pkg::tcb_dat_t wd;
    tcb_pkg::tcb_dat_t exp_rd;
    tcb_pkg::tcb_adr_t adr;
    logic [31:0]       r;
    logic [31:0]       r2;
    logic              seen;
    void'($urandom(32'h5487f4fc));
    rst_n   = 1'b0;
    gpio_in = '0;
    go_idle();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    assert (gpio_out == '0 && gpio_oe == '0) else
      stop_with_error($sformatf("Mismatch gpio_out/gpio_oe after reset: got %h/%h expected 00/00",
                                gpio_out, gpio_oe));
    assert (tcb_err == 1'b0) else
      stop_with_error($sformatf("Mismatch tcb_err after reset: got %h expected 0", tcb_err));
    read_word({8'h10, GPIO_OUT_OFS}, rd);
    assert (rd == '0) else
      stop_with_error($sformatf("Mismatch gpio out register: got %h expected 00000000", rd));

    // fill the whole memory back to back
    for (int w = 0; w < MEM_WORDS; w++) begin
      adr = 16'(w * 4);
      drive_xfer(1'b1, adr, 4'hf, fill_word(adr));
    end
    go_idle();

    // every byte enable pattern over the fill
    for (int b = 0; b < 16; b++) begin
      adr = 16'h0200 + 16'(b * 4);
      wd  = $urandom();
      write_word(adr, 4'(b), wd);
      read_word(adr, rd);
      for (int k = 0; k < 4; k++) begin
        exp_rd[8*k +: 8] = b[k] ? wd[8*k +: 8] : fill_word(adr) >> (8 * k);
      end
      assert (rd === exp_rd) else
        stop_with_error($sformatf("Mismatch tcb_rdt: got %h expected %h (ben %h)", rd, exp_rd, b));
    end

    // gpio outputs follow a write at its edge
    write_word({8'h10, GPIO_OUT_OFS}, 4'hf, 32'h000000a5);
    assert (gpio_out == 8'ha5) else
      stop_with_error($sformatf("Mismatch gpio_out: got %h expected a5", gpio_out));
    write_word({8'h10, GPIO_OE_OFS}, 4'hf, 32'h0000003c);
    assert (gpio_oe == 8'h3c) else
      stop_with_error($sformatf("Mismatch gpio_oe: got %h expected 3c", gpio_oe));
    read_word({8'h10, GPIO_OUT_OFS}, rd);
    assert (rd === 32'h000000a5) else
      stop_with_error($sformatf("Mismatch gpio out register: got %h expected 000000a5", rd));
    read_word({8'h10, GPIO_OE_OFS}, rd);
    assert (rd === 32'h0000003c) else
      stop_with_error($sformatf("Mismatch gpio oe register: got %h expected 0000003c", rd));

    // poll the input register through the synchronizer
    gpio_in = 8'h96;
    seen    = 1'b0;
    for (int n = 0; n < POLL_MAX && !seen; n++) begin
      read_word({8'h10, GPIO_IN_OFS}, rd);
      if (rd == 32'h00000096) seen = 1'b1;
    end
    assert (seen) else
      stop_with_error("timeout while polling the gpio input register for the driven value");

    // unmapped transfers touch nothing
    write_word(16'h2004, 4'hf, 32'hdeadbeef);
    assert (tcb_err === 1'b1 && tcb_rdt === '0) else
      stop_with_error($sformatf("Mismatch tcb_err/tcb_rdt: got %h/%h expected 1/00000000",
                                tcb_err, tcb_rdt));
    write_word(16'hf000, 4'hf, 32'h00000000);
    read_word(16'h3000, rd);
    read_word(16'h0004, rd);
    assert (rd === fill_word(16'h0004)) else
      stop_with_error($sformatf("Mismatch tcb_rdt: got %h expected %h", rd, fill_word(16'h0004)));
    assert (gpio_out == 8'ha5 && gpio_oe == 8'h3c) else
      stop_with_error($sformatf("Mismatch gpio_out/gpio_oe: got %h/%h expected a5/3c",
                                gpio_out, gpio_oe));

    // random traffic with one transfer per cycle
    for (int n = 0; n < RAND_XFERS; n++) begin
      r  = $urandom();
      r2 = $urandom();
      wd = $urandom();
      if (r[2:0] < 3'd5) adr = {4'h0, r[13:4], 2'b00};
      else if (r[2:0] < 3'd7) adr = {8'h10, 4'h0, r[9:8], 2'b00};
      else adr = {r[31:29] | 3'b001, r[28:16]};
      if (n % 32 == 31) gpio_in = r2[23:16];
      drive_xfer(r2[0], adr, r2[7:4], wd);
    end
    go_idle();
    // let the last response be checked
    repeat (2) @(posedge clk);

    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verilog/tcb_lib_decoder.sv */
// address decoder that maps a request address onto a subordinate select and a hit flag
`timescale 1ns/1ps

module tcb_lib_decoder #(
  // number of subordinate ports
  parameter int unsigned SPN = tcb_pkg::TCB_SPN_DEF,
  // select width, kept at least one bit wide
  localparam int unsigned SPL = (SPN > 1) ? $clog2(SPN) : 1,
  // wildcard address/mask per subordinate
  parameter tcb_pkg::tcb_adr_t DAM [SPN-1:0] = tcb_pkg::TCB_DAM_DEF
)(
  input  tcb_pkg::tcb_adr_t adr,
  output logic [SPL-1:0]    sel,
  output logic              hit
);

  //////////////////////////////////////////////////////////////////////
  // wildcard match
  //////////////////////////////////////////////////////////////////////

  // one match bit per subordinate
  logic [SPN-1:0] mch;

  generate
    for (genvar i = 0; i < SPN; i++) begin : g_mch
      // x bits in the constant are ignored by ==?
      assign mch[i] = (adr ==? DAM[i]);
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // priority encoder
  //////////////////////////////////////////////////////////////////////

  // any match at all
  assign hit = |mch;

  always_comb begin
    // zero when nothing matches, no unknowns downstream
    sel = '0;
    // walk down so the lowest index is assigned last
    for (int i = SPN - 1; i >= 0; i--) begin
      if (mch[i]) begin
        sel = i[SPL-1:0];
      end
    end
  end

endmodule

/* verilog/tcb_lib_demultiplexer.sv */
// request demultiplexer steering one manager to SPN subordinates with a 1 cycle response path
`timescale 1ns/1ps

module tcb_lib_demultiplexer #(
  // number of subordinate ports
  parameter int unsigned SPN = tcb_pkg::TCB_SPN_DEF,
  // select width, same rule as the decoder
  localparam int unsigned SPL = (SPN > 1) ? $clog2(SPN) : 1
)(
  input  logic              clk,
  input  logic              rst_n,
  // manager side
  input  logic              tcb_vld,
  input  logic              tcb_wen,
  input  tcb_pkg::tcb_adr_t tcb_adr,
  input  tcb_pkg::tcb_ben_t tcb_ben,
  input  tcb_pkg::tcb_dat_t tcb_wdt,
  output tcb_pkg::tcb_dat_t tcb_rdt,
  output logic              tcb_err,
  // from the decoder
  input  logic [SPL-1:0]    sel,
  input  logic              hit,
  // subordinate side
  output logic [SPN-1:0]    sub_vld,
  output logic              sub_wen,
  output tcb_pkg::tcb_adr_t sub_adr,
  output tcb_pkg::tcb_ben_t sub_ben,
  output tcb_pkg::tcb_dat_t sub_wdt,
  input  tcb_pkg::tcb_dat_t sub_rdt [SPN-1:0]
);

  //////////////////////////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////////////////////////

  // strobe only the selected subordinate
  generate
    for (genvar i = 0; i < SPN; i++) begin : g_vld
      assign sub_vld[i] = tcb_vld & hit & (sel == i[SPL-1:0]);
    end
  endgenerate

  // payload is shared, sub_vld qualifies it
  assign sub_wen = tcb_wen;
  assign sub_adr = tcb_adr;
  assign sub_ben = tcb_ben;
  assign sub_wdt = tcb_wdt;

  //////////////////////////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////////////////////////

  // select of the previous transfer
  logic [SPL-1:0] rsp_sel;
  // previous transfer was a mapped read
  logic           rsp_ren;
  // previous transfer hit no subordinate
  logic           rsp_mis;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_sel <= '0;
      rsp_ren <= 1'b0;
      rsp_mis <= 1'b0;
    end else begin
      // hold select between transfers
      if (tcb_vld) begin
        rsp_sel <= sel;
      end
      rsp_ren <= tcb_vld & ~tcb_wen & hit;
      rsp_mis <= tcb_vld & ~hit;
    end
  end

  // read data from the registered select, zero for writes and misses
  assign tcb_rdt = rsp_ren ? sub_rdt[rsp_sel] : '0;

  // error only for unmapped addresses
  assign tcb_err = rsp_mis;

endmodule

/* verilog/tcb_pkg.sv */
// shared bus widths, payload types and the default address map, referenced by scoped name

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  // byte address width
  parameter int unsigned TCB_ABW = 16;
  // data width
  parameter int unsigned TCB_DBW = 32;
  // one byte enable per data byte
  parameter int unsigned TCB_BEW = TCB_DBW / 8;

  //////////////////////////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////////////////////////

  typedef logic [TCB_ABW-1:0] tcb_adr_t;
  typedef logic [TCB_DBW-1:0] tcb_dat_t;
  typedef logic [TCB_BEW-1:0] tcb_ben_t;

  //////////////////////////////////////////////////////////////////////
  // default address map
  //////////////////////////////////////////////////////////////////////

  // subordinate count
  parameter int unsigned TCB_SPN_DEF = 2;

  // wildcard address per subordinate, x bits are don't care
  // lowest index wins on overlap
  parameter tcb_adr_t TCB_DAM_DEF [TCB_SPN_DEF-1:0] = '{
    // gpio register block
    0: 16'h10xx,
    // word memory, 4 KiB
    1: 16'h0xxx
  };

  // gpio pin count
  parameter int unsigned TCB_GPIO_W = 8;

endpackage

/* verilog/tcb_sub_gpio.sv */
// gpio register block subordinate with output, output enable and synchronized input registers
`timescale 1ns/1ps

module tcb_sub_gpio #(
  // pin count, up to the data width
  parameter int unsigned GPIO_W = tcb_pkg::TCB_GPIO_W
)(
  input  logic              clk,
  input  logic              rst_n,
  // bus
  input  logic              sub_vld,
  input  logic              sub_wen,
  input  tcb_pkg::tcb_adr_t sub_adr,
  input  tcb_pkg::tcb_ben_t sub_ben,
  input  tcb_pkg::tcb_dat_t sub_wdt,
  output tcb_pkg::tcb_dat_t sub_rdt,
  // pins
  input  logic [GPIO_W-1:0] gpio_in,
  output logic [GPIO_W-1:0] gpio_out,
  output logic [GPIO_W-1:0] gpio_oe
);

  // word offsets: 0x0 out, 0x4 oe, 0x8 in
  localparam logic [5:0] OFS_OUT = 6'd0;
  localparam logic [5:0] OFS_OE  = 6'd1;
  localparam logic [5:0] OFS_IN  = 6'd2;

  // word offset inside the 256 byte block
  logic [5:0] ofs;

  assign ofs = sub_adr[7:2];

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else if (sub_vld && sub_wen) begin
      // pin i belongs to byte i/8
      for (int i = 0; i < GPIO_W; i++) begin
        if (sub_ben[i/8]) begin
          if (ofs == OFS_OUT) gpio_out[i] <= sub_wdt[i];
          if (ofs == OFS_OE)  gpio_oe[i]  <= sub_wdt[i];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////////////////////////

  logic [GPIO_W-1:0] gpio_meta;
  // input register, second stage
  logic [GPIO_W-1:0] gpio_sync;

  always_ff @(posedge clk) begin
    gpio_meta <= gpio_in;
    gpio_sync <= gpio_meta;
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  tcb_pkg::tcb_dat_t rdt;

  always_comb begin
    // unused offsets read zero
    rdt = '0;
    case (ofs)
      OFS_OUT: rdt[GPIO_W-1:0] = gpio_out;
      OFS_OE:  rdt[GPIO_W-1:0] = gpio_oe;
      OFS_IN:  rdt[GPIO_W-1:0] = gpio_sync;
      default: rdt = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sub_vld) begin
      sub_rdt <= rdt;
    end
  end

endmodule

/* verilog/tcb_sub_memory.sv */
// single-port word memory subordinate with byte enables and 1 cycle registered read data
`timescale 1ns/1ps

module tcb_sub_memory #(
  // size in words, power of two
  parameter int unsigned DEPTH = 1024
)(
  input  logic              clk,
  input  logic              sub_vld,
  input  logic              sub_wen,
  input  tcb_pkg::tcb_adr_t sub_adr,
  input  tcb_pkg::tcb_ben_t sub_ben,
  input  tcb_pkg::tcb_dat_t sub_wdt,
  output tcb_pkg::tcb_dat_t sub_rdt
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // word index width
  localparam int unsigned AW = $clog2(DEPTH);

  tcb_pkg::tcb_dat_t mem [0:DEPTH-1];

  // word address, byte offset bits dropped
  logic [AW-1:0] idx;

  assign idx = sub_adr[AW+1:2];

  //////////////////////////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////////////////////////

  // write only enabled bytes
  always_ff @(posedge clk) begin
    if (sub_vld && sub_wen) begin
      for (int b = 0; b < tcb_pkg::TCB_BEW; b++) begin
        if (sub_ben[b]) begin
          mem[idx][8*b +: 8] <= sub_wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read on every strobe
  // demux discards it for writes
  always_ff @(posedge clk) begin
    if (sub_vld) begin
      sub_rdt <= mem[idx];
    end
  end

endmodule

/* verilog/tcb_subsystem_top.sv */
// subsystem top level joining one bus manager port to the gpio block and the word memory
`timescale 1ns/1ps

module tcb_subsystem_top #(
  // address map
  parameter int unsigned       SPN = tcb_pkg::TCB_SPN_DEF,
  parameter tcb_pkg::tcb_adr_t DAM [SPN-1:0] = tcb_pkg::TCB_DAM_DEF,
  // memory words
  parameter int unsigned       DEPTH = 1024,
  // gpio pins
  parameter int unsigned       GPIO_W = tcb_pkg::TCB_GPIO_W,
  // select width
  localparam int unsigned      SPL = (SPN > 1) ? $clog2(SPN) : 1
)(
  input  logic              clk,
  input  logic              rst_n,
  // manager port
  input  logic              tcb_vld,
  input  logic              tcb_wen,
  input  tcb_pkg::tcb_adr_t tcb_adr,
  input  tcb_pkg::tcb_ben_t tcb_ben,
  input  tcb_pkg::tcb_dat_t tcb_wdt,
  output tcb_pkg::tcb_dat_t tcb_rdt,
  output logic              tcb_err,
  // pins
  input  logic [GPIO_W-1:0] gpio_in,
  output logic [GPIO_W-1:0] gpio_out,
  output logic [GPIO_W-1:0] gpio_oe
);

  //////////////////////////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////////////////////////

  logic [SPL-1:0]    sel;
  logic              hit;
  logic [SPN-1:0]    sub_vld;
  logic              sub_wen;
  tcb_pkg::tcb_adr_t sub_adr;
  tcb_pkg::tcb_ben_t sub_ben;
  tcb_pkg::tcb_dat_t sub_wdt;
  tcb_pkg::tcb_dat_t sub_rdt [SPN-1:0];

  tcb_lib_decoder #(
    .SPN (SPN),
    .DAM (DAM)
  ) i_decoder (
    .adr (tcb_adr),
    .sel (sel),
    .hit (hit)
  );

  tcb_lib_demultiplexer #(
    .SPN (SPN)
  ) i_demultiplexer (
    .clk     (clk),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_wen (tcb_wen),
    .tcb_adr (tcb_adr),
    .tcb_ben (tcb_ben),
    .tcb_wdt (tcb_wdt),
    .tcb_rdt (tcb_rdt),
    .tcb_err (tcb_err),
    .sel     (sel),
    .hit     (hit),
    .sub_vld (sub_vld),
    .sub_wen (sub_wen),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdt (sub_rdt)
  );

  //////////////////////////////////////////////////////////////////////
  // subordinates
  //////////////////////////////////////////////////////////////////////

  // port 0, gpio at 0x10xx
  tcb_sub_gpio #(
    .GPIO_W (GPIO_W)
  ) i_gpio (
    .clk      (clk),
    .rst_n    (rst_n),
    .sub_vld  (sub_vld[0]),
    .sub_wen  (sub_wen),
    .sub_adr  (sub_adr),
    .sub_ben  (sub_ben),
    .sub_wdt  (sub_wdt),
    .sub_rdt  (sub_rdt[0]),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  // port 1, memory at 0x0xxx
  tcb_sub_memory #(
    .DEPTH (DEPTH)
  ) i_memory (
    .clk     (clk),
    .sub_vld (sub_vld[1]),
    .sub_wen (sub_wen),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdt (sub_rdt[1])
  );

endmodule
